// File: src/rmii_rx_pkg.sv
`default_nettype none

package rmii_rx_pkg;

    //////////////////////////////
    // Link speed and line codes
    //////////////////////////////

    typedef enum logic [1:0] {
        speed_10  = 2'd0,
        speed_100 = 2'd1
    } speed_t;

    localparam logic [1:0] dibit_preamble = 2'b01;
    localparam logic [1:0] dibit_sfd      = 2'b11;

    // Preamble dibits needed before the speed check
    localparam logic [7:0] preamble_run    = 8'd28;
    // Reference clocks per dibit at 10 Mb/s
    localparam logic [3:0] slot_clocks     = 4'd10;
    localparam logic [2:0] dibits_per_byte = 3'd4;

    //////////////////////////////
    // Shared records
    //////////////////////////////

    // One registered sample of the RMII receive pins
    typedef struct packed {
        logic [1:0] dibit;
        logic       enable;
        logic       error;
    } rmii_line_t;

    typedef struct packed {
        logic       first;
        logic [7:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic [10:0] byte_count;
        logic        errored;
        speed_t      speed;
    } frame_report_t;

endpackage

`default_nettype wire

// File: src/rmii_rx_sync_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module rmii_rx_sync_fsm (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire [1:0]                rxd,
    input  wire                      crs_dv,
    input  wire                      rx_er,
    output rmii_rx_pkg::rmii_line_t  line_q,
    input  wire                      run_full,
    input  wire                      sample_tick,
    output logic                     run_clear,
    output logic                     run_step,
    output logic                     slot_start,
    output logic                     slot_enable,
    output logic                     dibit_clear,
    output logic                     shift,
    output logic                     frame_start,
    output rmii_rx_pkg::speed_t      speed
);
    import rmii_rx_pkg::*;

    typedef enum logic [2:0] {
        st_sync,
        st_speed_check,
        st_preamble_10,
        st_sfd_slot_10,
        st_pack_100,
        st_pack_10
    } state_t;

    state_t state;
    state_t state_next;
    speed_t speed_next;
    logic   line_good;

    assign line_good = line_q.enable && !line_q.error;

    // Pin register
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            line_q <= '0;
        end else begin
            line_q.dibit  <= rxd;
            line_q.enable <= crs_dv;
            line_q.error  <= rx_er;
        end
    end

    always_comb begin
        state_next  = state;
        speed_next  = speed;
        run_clear   = 1'b1;
        run_step    = 1'b0;
        slot_start  = 1'b0;
        slot_enable = 1'b0;
        dibit_clear = 1'b1;
        shift       = 1'b0;
        frame_start = 1'b0;

        case (state)
            st_sync: begin
                if (line_good && line_q.dibit == dibit_preamble) begin
                    run_clear = 1'b0;
                    run_step  = 1'b1;
                    if (run_full) begin
                        state_next = st_speed_check;
                    end
                end
            end
            // Dibit after the run tells the speed
            st_speed_check: begin
                if (line_good && line_q.dibit == dibit_sfd) begin
                    state_next  = st_pack_100;
                    speed_next  = speed_100;
                    frame_start = 1'b1;
                end else if (line_good && line_q.dibit == dibit_preamble) begin
                    state_next = st_preamble_10;
                end else begin
                    state_next = st_sync;
                end
            end
            st_preamble_10: begin
                if (line_good && line_q.dibit == dibit_sfd) begin
                    state_next  = st_sfd_slot_10;
                    speed_next  = speed_10;
                    slot_start  = 1'b1;
                    frame_start = 1'b1;
                end else if (!(line_good && line_q.dibit == dibit_preamble)) begin
                    state_next = st_sync;
                end
            end
            // Let the SFD slot run out
            st_sfd_slot_10: begin
                slot_enable = 1'b1;
                if (!line_good) begin
                    state_next = st_sync;
                end else if (sample_tick) begin
                    state_next = st_pack_10;
                end
            end
            st_pack_100: begin
                dibit_clear = 1'b0;
                if (line_good) begin
                    shift = 1'b1;
                end else begin
                    state_next = st_sync;
                end
            end
            st_pack_10: begin
                dibit_clear = 1'b0;
                slot_enable = 1'b1;
                if (line_good) begin
                    shift = sample_tick;
                end else begin
                    state_next = st_sync;
                end
            end
            default: begin
                state_next = st_sync;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= st_sync;
            speed <= speed_100;
        end else begin
            state <= state_next;
            speed <= speed_next;
        end
    end

endmodule

`default_nettype wire

// File: src/rmii_dibit_timer.sv
`timescale 1ns/10ps
`default_nettype none

module rmii_dibit_timer (
    input  wire   clock,
    input  wire   reset_n,
    input  wire   run_clear,
    input  wire   run_step,
    output logic  run_full,
    input  wire   slot_start,
    input  wire   slot_enable,
    output logic  sample_tick,
    input  wire   dibit_clear,
    input  wire   shift,
    output logic  byte_tick
);
    import rmii_rx_pkg::*;

    logic [7:0] run_count;
    logic [3:0] slot_count;
    logic [1:0] dibit_count;

    // High while the current preamble dibit completes the run
    assign run_full    = run_count >= preamble_run - 8'd1;
    assign sample_tick = slot_count == slot_clocks - 4'd1;
    assign byte_tick   = shift && ({1'b0, dibit_count} == dibits_per_byte - 3'd1);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            run_count   <= '0;
            slot_count  <= '0;
            dibit_count <= '0;
        end else begin
            if (run_clear) begin
                run_count <= '0;
            end else if (run_step && run_count != preamble_run) begin
                run_count <= run_count + 8'd1;
            end

            // Start clock is already the first of the slot
            if (slot_start) begin
                slot_count <= 4'd1;
            end else if (slot_enable) begin
                slot_count <= sample_tick ? 4'd0 : slot_count + 4'd1;
            end

            if (dibit_clear) begin
                dibit_count <= '0;
            end else if (shift) begin
                dibit_count <= dibit_count + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rmii_byte_assembler.sv
`timescale 1ns/10ps
`default_nettype none

module rmii_byte_assembler (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire rmii_rx_pkg::rmii_line_t line_q,
    input  wire                      shift,
    input  wire                      byte_tick,
    input  wire                      frame_start,
    output rmii_rx_pkg::rx_byte_t    rx_byte,
    output logic                     rx_byte_valid
);

    logic [7:0] shift_q;
    logic [7:0] shift_next;
    logic       first_pending;

    // LSB dibit arrives first, so new dibits enter at the top
    assign shift_next = {line_q.dibit, shift_q[7:2]};

    always_ff @(posedge clock) begin
        if (shift) begin
            shift_q <= shift_next;
        end
        if (byte_tick) begin
            rx_byte.data  <= shift_next;
            rx_byte.first <= first_pending;
        end
    end

    //////////////////////////////
    // Strobe and first flag
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rx_byte_valid <= 1'b0;
            first_pending <= 1'b0;
        end else begin
            rx_byte_valid <= byte_tick;
            if (frame_start) begin
                first_pending <= 1'b1;
            end else if (byte_tick) begin
                first_pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rmii_frame_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module rmii_frame_monitor (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire rmii_rx_pkg::rmii_line_t line_q,
    input  wire                          frame_start,
    input  wire rmii_rx_pkg::speed_t     speed,
    input  wire                          rx_byte_valid,
    output rmii_rx_pkg::frame_report_t   frame_report,
    output logic                         frame_done
);

    logic        in_frame;
    logic [10:0] byte_count;
    logic [10:0] count_total;
    logic        frame_end;

    assign frame_end   = in_frame && (!line_q.enable || line_q.error);
    // Last byte strobe can land on the ending cycle
    assign count_total = byte_count + {10'd0, rx_byte_valid};

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            in_frame   <= 1'b0;
            byte_count <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= frame_end;
            if (frame_start) begin
                in_frame   <= 1'b1;
                byte_count <= '0;
            end else if (frame_end) begin
                in_frame <= 1'b0;
            end else if (in_frame) begin
                byte_count <= count_total;
            end
        end
    end

    // Report of the frame just ended
    always_ff @(posedge clock) begin
        if (frame_end) begin
            frame_report.byte_count <= count_total;
            frame_report.errored    <= line_q.error;
            frame_report.speed      <= speed;
        end
    end

endmodule

`default_nettype wire

// File: src/rmii_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module rmii_rx_top (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire [1:0]                   rxd,
    input  wire                         crs_dv,
    input  wire                         rx_er,
    output rmii_rx_pkg::rx_byte_t       rx_byte,
    output logic                        rx_byte_valid,
    output rmii_rx_pkg::frame_report_t  frame_report,
    output logic                        frame_done,
    output rmii_rx_pkg::speed_t         speed
);
    import rmii_rx_pkg::*;

    rmii_line_t line_q;
    logic       run_clear;
    logic       run_step;
    logic       run_full;
    logic       slot_start;
    logic       slot_enable;
    logic       sample_tick;
    logic       dibit_clear;
    logic       shift;
    logic       byte_tick;
    logic       frame_start;

    //////////////////////////////
    // Control
    //////////////////////////////

    rmii_rx_sync_fsm sync_fsm_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .rxd         (rxd),
        .crs_dv      (crs_dv),
        .rx_er       (rx_er),
        .line_q      (line_q),
        .run_full    (run_full),
        .sample_tick (sample_tick),
        .run_clear   (run_clear),
        .run_step    (run_step),
        .slot_start  (slot_start),
        .slot_enable (slot_enable),
        .dibit_clear (dibit_clear),
        .shift       (shift),
        .frame_start (frame_start),
        .speed       (speed)
    );

    rmii_dibit_timer dibit_timer_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .run_clear   (run_clear),
        .run_step    (run_step),
        .run_full    (run_full),
        .slot_start  (slot_start),
        .slot_enable (slot_enable),
        .sample_tick (sample_tick),
        .dibit_clear (dibit_clear),
        .shift       (shift),
        .byte_tick   (byte_tick)
    );

    //////////////////////////////
    // Data path
    //////////////////////////////

    rmii_byte_assembler byte_assembler_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .line_q        (line_q),
        .shift         (shift),
        .byte_tick     (byte_tick),
        .frame_start   (frame_start),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid)
    );

    rmii_frame_monitor frame_monitor_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .line_q        (line_q),
        .frame_start   (frame_start),
        .speed         (speed),
        .rx_byte_valid (rx_byte_valid),
        .frame_report  (frame_report),
        .frame_done    (frame_done)
    );

endmodule

`default_nettype wire

// File: sim/rmii_rx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rmii_rx_tb;
    import rmii_rx_pkg::*;

    // Frame length in clocks is (preamble + SFD + 4 per byte) dibits times the hold
    localparam int frame_clocks  = (29 + 4 * 20) + 10 * (29 + 4 * 12) + (21 + 4 * 8)
                                 + (29 + 4 * 10) + (29 + 4 * 8) + 10 * (29 + 4 * 6)
                                 + (29 + 4 * 9);
    localparam int margin_clocks = 400;
    localparam int watchdog_ns   = (frame_clocks + margin_clocks) * 20;
    localparam int no_error      = 1 << 20;

    logic          clock;
    logic          reset_n;
    logic [1:0]    rxd;
    logic          crs_dv;
    logic          rx_er;
    rx_byte_t      rx_byte;
    logic          rx_byte_valid;
    frame_report_t frame_report;
    logic          frame_done;
    speed_t        speed;

    // Scoreboard
    logic [7:0]    exp_data_q[$];
    logic          exp_first_q[$];
    frame_report_t exp_report_q[$];
    logic [7:0]    payload[$];
    bit            valid_due [0:4095];
    bit            done_due [0:4095];
    logic [11:0]   cycle = '0;
    int            got_count = 0;
    int            done_count = 0;
    int            error_count = 0;
    int            errors_before = 0;
    int            tests_run = 0;
    int            tests_failed = 0;

    rmii_rx_top dut_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .rxd           (rxd),
        .crs_dv        (crs_dv),
        .rx_er         (rx_er),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .frame_report  (frame_report),
        .frame_done    (frame_done),
        .speed         (speed)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 12'd1;
        if (reset_n && rx_byte_valid) begin
            got_count <= got_count + 1;
        end
        if (reset_n && frame_done) begin
            done_count <= done_count + 1;
        end
    end

    ////////////////////////////////
    // Checks
    ////////////////////////////////

    // Strobes land exactly two clocks after the line change behind them
    assert property (@(posedge clock) disable iff (!reset_n) rx_byte_valid == valid_due[cycle])
    else begin
        error_count++;
        $display("ERR rx_byte_valid exp %h got %h", valid_due[$sampled(cycle)],
                 $sampled(rx_byte_valid));
    end

    assert property (@(posedge clock) disable iff (!reset_n) frame_done == done_due[cycle])
    else begin
        error_count++;
        $display("ERR frame_done exp %h got %h", done_due[$sampled(cycle)],
                 $sampled(frame_done));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        rx_byte_valid |-> rx_byte.data == exp_data_q[got_count])
    else begin
        error_count++;
        $display("ERR rx_byte.data exp %h got %h", exp_data_q[$sampled(got_count)],
                 $sampled(rx_byte.data));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        rx_byte_valid |-> rx_byte.first == exp_first_q[got_count])
    else begin
        error_count++;
        $display("ERR rx_byte.first exp %h got %h", exp_first_q[$sampled(got_count)],
                 $sampled(rx_byte.first));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        frame_done |-> frame_report == exp_report_q[done_count])
    else begin
        error_count++;
        $display("ERR frame_report exp %h got %h", exp_report_q[$sampled(done_count)],
                 $sampled(frame_report));
    end

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////

    task automatic drive_line(input logic [1:0] dibit, input logic enable, input logic err,
                              input int hold, input bit byte_end, input bit frame_end);
        int n;
        for (n = 0; n < hold; n++) begin
            @(posedge clock);
            #2;
            rxd    = dibit;
            crs_dv = enable;
            rx_er  = err;
        end
        // Last clock of the hold is the one taken
        if (byte_end) begin
            valid_due[cycle + 12'd2] = 1'b1;
        end
        if (frame_end) begin
            done_due[cycle + 12'd2] = 1'b1;
        end
    endtask

    task automatic fill_payload(input int nbytes);
        int i;
        payload.delete();
        for (i = 0; i < nbytes; i++) begin
            payload.push_back(8'($urandom_range(255, 0)));
        end
    endtask

    task automatic send_frame(input speed_t link, input int pre_len, input int nbytes,
                              input int err_byte);
        int            hold;
        int            i;
        int            k;
        bit            synced;
        bit            live;
        logic [7:0]    bits;
        frame_report_t rep;
        hold   = (link == speed_10) ? int'(slot_clocks) : 1;
        synced = pre_len >= int'(preamble_run);
        // Report is queued before the line can end the frame
        if (synced) begin
            rep.byte_count = 11'((err_byte < nbytes) ? err_byte : nbytes);
            rep.errored    = err_byte < nbytes;
            rep.speed      = link;
            exp_report_q.push_back(rep);
        end
        for (i = 0; i < pre_len; i++) begin
            drive_line(dibit_preamble, 1'b1, 1'b0, hold, 1'b0, 1'b0);
        end
        drive_line(dibit_sfd, 1'b1, 1'b0, hold, 1'b0, 1'b0);
        for (i = 0; i < nbytes; i++) begin
            // One clock of rx_er, then the rest of the payload must be dropped
            if (i == err_byte) begin
                drive_line(2'b00, 1'b1, 1'b1, 1, 1'b0, synced);
            end
            live = synced && i < err_byte;
            bits = payload[i];
            // Least significant dibit goes out first
            for (k = 0; k < 4; k++) begin
                drive_line(bits[1:0], 1'b1, 1'b0, hold, live && k == 3, 1'b0);
                bits = bits >> 2;
            end
            if (live) begin
                exp_data_q.push_back(payload[i]);
                exp_first_q.push_back(i == 0);
            end
        end
        drive_line(2'b00, 1'b0, 1'b0, 1, 1'b0, synced && err_byte >= nbytes);
    endtask

    task automatic wait_frame_done(input int limit);
        int n;
        n = 0;
        while (done_count != exp_report_q.size() && n < limit) begin
            @(posedge clock);
            #1;
            n++;
        end
        assert (done_count == exp_report_q.size())
        else begin
            error_count++;
            $display("No frame_done within %0d clocks of the frame end", limit);
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clock);
        #1;
        assert (got_count == exp_data_q.size())
        else begin
            error_count++;
            $display("Saw %0d byte strobes where %0d were expected", got_count,
                     exp_data_q.size());
        end
        assert (done_count == exp_report_q.size())
        else begin
            error_count++;
            $display("Saw %0d frame reports where %0d were expected", done_count,
                     exp_report_q.size());
        end
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed", name);
        end
        errors_before = error_count;
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns with tests still running", watchdog_ns);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clock   = 1'b0;
        reset_n = 1'b0;
        rxd     = 2'b00;
        crs_dv  = 1'b0;
        rx_er   = 1'b0;
        void'($urandom(32'h9982));
        repeat (5) @(posedge clock);
        #2;
        reset_n = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        assert (speed == speed_100)
        else begin
            error_count++;
            $display("ERR speed exp %h got %h", speed_100, speed);
        end

        fill_payload(20);
        send_frame(speed_100, 28, 20, no_error);
        wait_frame_done(10);
        end_test("1 random frame at 100 Mb/s");

        fill_payload(12);
        send_frame(speed_10, 28, 12, no_error);
        wait_frame_done(10);
        assert (speed == speed_10)
        else begin
            error_count++;
            $display("ERR speed exp %h got %h", speed_10, speed);
        end
        end_test("2 frame at 10 Mb/s");

        // Too short to sync, so nothing may come out
        fill_payload(8);
        send_frame(speed_100, 20, 8, no_error);
        repeat (10) @(posedge clock);
        end_test("3 short preamble");

        fill_payload(10);
        send_frame(speed_100, 28, 10, 5);
        wait_frame_done(10);
        end_test("4 rx_er inside a frame");

        fill_payload(8);
        send_frame(speed_100, 28, 8, no_error);
        wait_frame_done(10);
        end_test("5 strobe and report timing");

        fill_payload(6);
        send_frame(speed_10, 28, 6, no_error);
        wait_frame_done(10);
        fill_payload(9);
        send_frame(speed_100, 28, 9, no_error);
        wait_frame_done(10);
        end_test("6 back to back frames at both speeds");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/rmii_rx_pkg.sv
src/rmii_rx_sync_fsm.sv
src/rmii_dibit_timer.sv
src/rmii_byte_assembler.sv
src/rmii_frame_monitor.sv
src/rmii_rx_top.sv
sim/rmii_rx_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := rmii_rx_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_TEXT := TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
